/* verilog.f */
rtl/wb_bus_pkg.sv
rtl/wb_map_pkg.sv
rtl/wb_bus_if.sv
rtl/wb_intercon.sv
rtl/wb_ram.sv
rtl/riscv_timer.sv
rtl/wb_sim_io.sv
rtl/serv_subsys.sv
bench/tb_serv_subsys.sv

/* run.sh */
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_serv_subsys --Mdir obj_dir -f verilog.f
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/Vtb_serv_subsys)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_out" | grep -qx "ALL TESTS PASSED"; then
   exit 0
fi
exit 1

/* bench/tb_serv_subsys.sv */
`timescale 1ns/10ps

module tb_serv_subsys;

   localparam int CLK_HALF       = 20;
   localparam int DRIVE_DLY      = 2;
   localparam int TIMEOUT_CYCLES = 4000;
   localparam int ACK_LIMIT      = 20;   // cycles one transfer may take
   localparam int N_WORDS        = 32;

   logic        wb_clk;
   logic        wb_rst;
   logic [31:0] ibus_adr;
   logic        ibus_cyc;
   logic [31:0] ibus_rdt;
   logic        ibus_ack;
   logic [31:0] dbus_adr;
   logic [31:0] dbus_dat;
   logic [3:0]  dbus_sel;
   logic        dbus_we;
   logic        dbus_cyc;
   logic [31:0] dbus_rdt;
   logic        dbus_ack;
   logic        timer_irq;
   logic        gpio;
   logic        print_valid;
   logic [7:0]  print_char;
   logic        halt;

   logic [31:0] ref_mem [2048];
   logic [31:0] addr_list [N_WORDS];
   logic [31:0] rng;
   logic [7:0]  print_last;
   int          errors = 0;
   int          cycle_cnt = 0;
   int          print_count;
   int          dbus_ack_cyc;
   int          ibus_ack_cyc;

   serv_subsys i_serv_subsys (
      .wb_clk        (wb_clk),
      .wb_rst        (wb_rst),
      .i_ibus_adr    (ibus_adr),
      .i_ibus_cyc    (ibus_cyc),
      .o_ibus_rdt    (ibus_rdt),
      .o_ibus_ack    (ibus_ack),
      .i_dbus_adr    (dbus_adr),
      .i_dbus_dat    (dbus_dat),
      .i_dbus_sel    (dbus_sel),
      .i_dbus_we     (dbus_we),
      .i_dbus_cyc    (dbus_cyc),
      .o_dbus_rdt    (dbus_rdt),
      .o_dbus_ack    (dbus_ack),
      .o_timer_irq   (timer_irq),
      .o_gpio        (gpio),
      .o_print_valid (print_valid),
      .o_print_char  (print_char),
      .o_halt        (halt)
   );

   initial begin
      wb_clk = 1'b0;
      forever #CLK_HALF wb_clk = ~wb_clk;
   end

   always @(posedge wb_clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("timeout: the run went past %0d cycles without finishing", TIMEOUT_CYCLES);
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

   always @(negedge wb_clk) begin
      if (!wb_rst && print_valid) begin   // count print pulses
         print_count++;
         print_last = print_char;
      end
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act) begin
         errors++;
         $display("ERR %s: expected 0x%08h, actual 0x%08h", name, exp, act);
      end
   endtask

   task automatic report_failure(input string msg);
      errors++;
      $display("%s", msg);
   endtask

   // samples ack at the falling edge and drops cyc after the next rising edge
   task automatic wait_ack(input bit on_ibus, output logic [31:0] data);
      int n;
      n = 0;
      @(negedge wb_clk);
      while (!(on_ibus ? ibus_ack : dbus_ack) && n < ACK_LIMIT) begin
         @(negedge wb_clk);
         n++;
      end
      if (!(on_ibus ? ibus_ack : dbus_ack))
         report_failure($sformatf("%s transfer got no ack", on_ibus ? "ibus" : "dbus"));
      data = on_ibus ? ibus_rdt : dbus_rdt;
      if (on_ibus)
         ibus_ack_cyc = cycle_cnt;
      else
         dbus_ack_cyc = cycle_cnt;
      @(posedge wb_clk);
      #DRIVE_DLY;
      if (on_ibus) begin
         ibus_cyc = 1'b0;
      end else begin
         dbus_cyc = 1'b0;
         dbus_we  = 1'b0;
      end
   endtask

   task automatic dbus_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] sel);
      logic [31:0] unused;
      @(posedge wb_clk);
      #DRIVE_DLY;
      dbus_adr = addr;
      dbus_dat = data;
      dbus_sel = sel;
      dbus_we  = 1'b1;
      dbus_cyc = 1'b1;
      wait_ack(1'b0, unused);
      if (addr[31:28] == 4'h0) begin   // ram region
         for (int b = 0; b < 4; b++) begin
            if (sel[b])
               ref_mem[addr[12:2]][8*b +: 8] = data[8*b +: 8];
         end
      end
   endtask

   task automatic dbus_read(input logic [31:0] addr, output logic [31:0] data);
      @(posedge wb_clk);
      #DRIVE_DLY;
      dbus_adr = addr;
      dbus_sel = 4'hF;
      dbus_we  = 1'b0;
      dbus_cyc = 1'b1;
      wait_ack(1'b0, data);
   endtask

   task automatic ibus_fetch(input logic [31:0] addr, output logic [31:0] data);
      @(posedge wb_clk);
      #DRIVE_DLY;
      ibus_adr = addr;
      ibus_cyc = 1'b1;
      wait_ack(1'b1, data);
   endtask

   task automatic ram_byte_select();
      logic [31:0] data;
      logic [31:0] rd;
      for (int i = 0; i < N_WORDS; i++) begin
         rng = xorshift32(rng);
         addr_list[i] = {19'h0, rng[10:0], 2'b00};
         rng = xorshift32(rng);
         dbus_write(addr_list[i], rng, 4'hF);   // every byte defined first
         rng = xorshift32(rng);
         data = rng;
         rng = xorshift32(rng);
         dbus_write(addr_list[i], data, rng[3:0]);
      end
      for (int i = 0; i < N_WORDS; i++) begin
         dbus_read(addr_list[i], rd);
         check("ram_bytes", ref_mem[addr_list[i][12:2]], rd);
      end
   endtask

   task automatic shared_ram_fetch();
      logic [31:0] rd;
      for (int i = 0; i < N_WORDS; i++) begin
         ibus_fetch(addr_list[i], rd);
         check("ifetch", ref_mem[addr_list[i][12:2]], rd);
      end
   endtask

   task automatic master_arbitration();
      logic [31:0] i_data;
      logic [31:0] d_data;
      rng = xorshift32(rng);
      dbus_write(32'h0000_0040, rng, 4'hF);   // word 16
      rng = xorshift32(rng);
      dbus_write(32'h0000_0FA0, rng, 4'hF);   // word 1000
      fork
         ibus_fetch(32'h0000_0040, i_data);
         dbus_read(32'h0000_0FA0, d_data);
      join
      check("arb_ibus_data", ref_mem[16], i_data);
      check("arb_dbus_data", ref_mem[1000], d_data);
      if (!(dbus_ack_cyc < ibus_ack_cyc))
         report_failure($sformatf(
            "arbitration: dbus ack in cycle %0d is not before ibus ack in cycle %0d",
            dbus_ack_cyc, ibus_ack_cyc));
   endtask

   task automatic timer_irq_compare();
      logic [31:0] t1;
      logic [31:0] t2;
      logic [31:0] t3;
      logic [31:0] rd;
      dbus_read(32'h8000_0000, t1);
      repeat (10) @(posedge wb_clk);
      dbus_read(32'h8000_0000, t2);
      if (t2 - t1 < 32'd10)
         report_failure($sformatf("timer: mtime advanced only %0d over 10 idle cycles", t2 - t1));
      dbus_read(32'h8000_0000, t3);
      dbus_write(32'h8000_0004, t3 + 32'd40, 4'hF);
      check("irq_after_write", 32'h0, 32'(timer_irq));
      dbus_read(32'h8000_0004, rd);
      check("mtimecmp_read", t3 + 32'd40, rd);
      repeat (60) @(posedge wb_clk);
      #DRIVE_DLY;
      check("irq_raised", 32'h1, 32'(timer_irq));
      dbus_write(32'h8000_0004, 32'hFFFF_FFFF, 4'hF);
      repeat (2) @(posedge wb_clk);
      #DRIVE_DLY;
      check("irq_cleared", 32'h0, 32'(timer_irq));
   endtask

   task automatic sim_io_and_unmapped();
      logic [31:0] rd;
      logic [7:0]  ch;
      dbus_write(32'h4000_0000, 32'h1, 4'hF);
      check("gpio_out", 32'h1, 32'(gpio));
      dbus_read(32'h4000_0000, rd);
      check("gpio_read", 32'h1, rd);
      rng = xorshift32(rng);
      ch = rng[7:0];
      print_count = 0;
      dbus_write(32'h4000_0004, {24'h0, ch}, 4'hF);
      repeat (5) @(posedge wb_clk);
      #DRIVE_DLY;
      check("print_count", 32'd1, 32'(print_count));
      check("print_char", {24'h0, ch}, {24'h0, print_last});
      dbus_write(32'h4000_0008, 32'h1, 4'hF);
      check("halt_set", 32'h1, 32'(halt));
      repeat (10) @(posedge wb_clk);
      #DRIVE_DLY;
      check("halt_sticky", 32'h1, 32'(halt));
      dbus_read(32'hF000_0000, rd);   // unmapped region
      check("unmapped_read", 32'h0, rd);
   endtask

   initial begin
      rng          = 32'd39335;
      print_count  = 0;
      print_last   = 8'h00;
      dbus_ack_cyc = 0;
      ibus_ack_cyc = 0;
      wb_rst       = 1'b1;
      ibus_adr     = 32'h0;
      ibus_cyc     = 1'b0;
      dbus_adr     = 32'h0;
      dbus_dat     = 32'h0;
      dbus_sel     = 4'h0;
      dbus_we      = 1'b0;
      dbus_cyc     = 1'b0;
      for (int i = 0; i < 2048; i++)
         ref_mem[i] = 32'h0;
      repeat (8) @(posedge wb_clk);
      #DRIVE_DLY;
      wb_rst = 1'b0;
      check("reset_outputs", 32'h0,
            {26'h0, ibus_ack, dbus_ack, timer_irq, gpio, print_valid, halt});
      ram_byte_select();
      shared_ram_fetch();
      master_arbitration();
      timer_irq_compare();
      sim_io_and_unmapped();
      $display("tests done after %0d cycles, errors: %0d", cycle_cnt, errors);
      if (errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

/* rtl/serv_subsys.sv */
`timescale 1ns/10ps

module serv_subsys (
   input  logic                         wb_clk,
   input  logic                         wb_rst,
   input  logic [wb_bus_pkg::WB_AW-1:0] i_ibus_adr,
   input  logic                         i_ibus_cyc,
   output logic [wb_bus_pkg::WB_DW-1:0] o_ibus_rdt,
   output logic                         o_ibus_ack,
   input  logic [wb_bus_pkg::WB_AW-1:0] i_dbus_adr,
   input  logic [wb_bus_pkg::WB_DW-1:0] i_dbus_dat,
   input  logic [wb_bus_pkg::WB_SW-1:0] i_dbus_sel,
   input  logic                         i_dbus_we,
   input  logic                         i_dbus_cyc,
   output logic [wb_bus_pkg::WB_DW-1:0] o_dbus_rdt,
   output logic                         o_dbus_ack,
   output logic                         o_timer_irq,
   output logic                         o_gpio,
   output logic                         o_print_valid,
   output logic [7:0]                   o_print_char,
   output logic                         o_halt
);
   import wb_bus_pkg::*;

   wb_bus_if ibus ();
   wb_bus_if dbus ();
   wb_bus_if ram_bus ();
   wb_bus_if io_bus ();
   wb_bus_if tmr_bus ();

   // instruction bus is read only, full words
   assign ibus.adr.raw = i_ibus_adr;
   assign ibus.dat_w   = {WB_DW{1'b0}};
   assign ibus.sel     = {WB_SW{1'b1}};
   assign ibus.we      = 1'b0;
   assign ibus.cyc     = i_ibus_cyc;
   assign o_ibus_rdt   = ibus.dat_r;
   assign o_ibus_ack   = ibus.ack;

   assign dbus.adr.raw = i_dbus_adr;
   assign dbus.dat_w   = i_dbus_dat;
   assign dbus.sel     = i_dbus_sel;
   assign dbus.we      = i_dbus_we;
   assign dbus.cyc     = i_dbus_cyc;
   assign o_dbus_rdt   = dbus.dat_r;
   assign o_dbus_ack   = dbus.ack;

   wb_intercon intercon (
      .wb_clk (wb_clk),
      .wb_rst (wb_rst),
      .i_ibus (ibus.slave),
      .i_dbus (dbus.slave),
      .o_ram  (ram_bus.master),
      .o_io   (io_bus.master),
      .o_tmr  (tmr_bus.master)
   );

   wb_ram ram (
      .wb_clk (wb_clk),
      .wb_rst (wb_rst),
      .i_bus  (ram_bus.slave)
   );

   riscv_timer timer (
      .wb_clk (wb_clk),
      .wb_rst (wb_rst),
      .i_bus  (tmr_bus.slave),
      .o_irq  (o_timer_irq)
   );

   wb_sim_io sim_io (
      .wb_clk        (wb_clk),
      .wb_rst        (wb_rst),
      .i_bus         (io_bus.slave),
      .o_gpio        (o_gpio),
      .o_print_valid (o_print_valid),
      .o_print_char  (o_print_char),
      .o_halt        (o_halt)
   );

endmodule

/* rtl/wb_sim_io.sv */
`timescale 1ns/10ps

module wb_sim_io (
   input  logic       wb_clk,
   input  logic       wb_rst,
   wb_bus_if.slave    i_bus,
   output logic       o_gpio,
   output logic       o_print_valid,
   output logic [7:0] o_print_char,
   output logic       o_halt
);
   import wb_bus_pkg::*;
   import wb_map_pkg::*;

   logic             wr;
   logic             ack_q;
   logic             gpio_q;
   logic             print_valid_q;
   logic [7:0]       print_char_q;
   logic             halt_q;
   logic [WB_DW-1:0] rdat_q;

   assign wr = i_bus.cyc & i_bus.we & ~ack_q;

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         ack_q         <= 1'b0;
         gpio_q        <= 1'b0;
         print_valid_q <= 1'b0;
         halt_q        <= 1'b0;
      end else begin
         ack_q         <= i_bus.cyc & ~ack_q;
         print_valid_q <= wr & (i_bus.adr.fields.word == IO_PRINT); // lines up with ack
         if (wr && i_bus.adr.fields.word == IO_GPIO) begin
            gpio_q <= i_bus.dat_w[0];
         end
         if (wr && i_bus.adr.fields.word == IO_HALT) begin
            halt_q <= 1'b1; // sticky
         end
      end
   end

   always_ff @(posedge wb_clk) begin
      if (wr && i_bus.adr.fields.word == IO_PRINT) begin
         print_char_q <= i_bus.dat_w[7:0];
      end
      rdat_q <= (i_bus.adr.fields.word == IO_GPIO) ? {{(WB_DW-1){1'b0}}, gpio_q} : '0;
   end

   assign i_bus.dat_r   = rdat_q;
   assign i_bus.ack     = ack_q;
   assign o_gpio        = gpio_q;
   assign o_print_valid = print_valid_q;
   assign o_print_char  = print_char_q;
   assign o_halt        = halt_q;

   a_print_pulse: assert property (@(posedge wb_clk) disable iff (wb_rst)
      o_print_valid |=> !o_print_valid);

endmodule

/* rtl/riscv_timer.sv */
`timescale 1ns/10ps

module riscv_timer (
   input  logic    wb_clk,
   input  logic    wb_rst,
   wb_bus_if.slave i_bus,
   output logic    o_irq
);
   import wb_bus_pkg::*;
   import wb_map_pkg::*;

   logic [WB_DW-1:0] mtime;
   logic [WB_DW-1:0] mtimecmp;
   logic [WB_DW-1:0] rdat_q;
   logic             ack_q;
   logic             irq_q;
   logic             cmp_wr;

   assign cmp_wr = i_bus.cyc & i_bus.we & ~ack_q
                   & (i_bus.adr.fields.word == TMR_MTIMECMP);

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         mtime    <= '0;
         mtimecmp <= '1;    // no interrupt until programmed
         ack_q    <= 1'b0;
         irq_q    <= 1'b0;
      end else begin
         mtime <= mtime + 1'b1;
         if (cmp_wr) begin
            mtimecmp <= i_bus.dat_w;
         end
         ack_q <= i_bus.cyc & ~ack_q;
         irq_q <= (mtime >= mtimecmp); // unsigned
      end
   end

   always_ff @(posedge wb_clk) begin
      case (i_bus.adr.fields.word)
         TMR_MTIME:    rdat_q <= mtime;
         TMR_MTIMECMP: rdat_q <= mtimecmp;
         default:      rdat_q <= '0;
      endcase
   end

   assign i_bus.dat_r = rdat_q;
   assign i_bus.ack   = ack_q;
   assign o_irq       = irq_q;

endmodule

/* rtl/wb_ram.sv */
`timescale 1ns/10ps

module wb_ram (
   input logic     wb_clk,
   input logic     wb_rst,
   wb_bus_if.slave i_bus
);
   import wb_bus_pkg::*;
   import wb_map_pkg::*;

   logic [WB_DW-1:0]  mem [RAM_WORDS];
   logic [RAM_AW-1:0] idx;
   logic              wr;
   logic              ack_q;
   logic [WB_DW-1:0]  rdat_q;

   assign idx = i_bus.adr.fields.word[RAM_AW-1:0];
   assign wr  = i_bus.cyc & i_bus.we & ~ack_q; // first cycle of a write

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= i_bus.cyc & ~ack_q;
      end
   end

   always_ff @(posedge wb_clk) begin
      if (wr) begin
         for (int b = 0; b < WB_SW; b++) begin
            if (i_bus.sel[b]) begin
               mem[idx][8*b +: 8] <= i_bus.dat_w[8*b +: 8];
            end
         end
      end
      rdat_q <= mem[idx];
   end

   assign i_bus.dat_r = rdat_q;
   assign i_bus.ack   = ack_q;

   // upper word bits past the ram depth must stay clear
   a_in_range: assert property (@(posedge wb_clk) disable iff (wb_rst)
      i_bus.cyc |-> ((i_bus.adr.fields.word >> RAM_AW) == '0));

endmodule

/* rtl/wb_intercon.sv */
`timescale 1ns/10ps

module wb_intercon (
   input logic      wb_clk,
   input logic      wb_rst,
   wb_bus_if.slave  i_ibus,
   wb_bus_if.slave  i_dbus,
   wb_bus_if.master o_ram,
   wb_bus_if.master o_io,
   wb_bus_if.master o_tmr
);
   import wb_bus_pkg::*;
   import wb_map_pkg::*;

   logic [1:0]       gnt_q;    // {dbus, ibus}, zero when idle
   logic             idle;
   logic             sel_d;
   logic             sel_i;
   wb_addr_u         m_adr;
   logic [WB_DW-1:0] m_dat_w;
   logic [WB_SW-1:0] m_sel;
   logic             m_we;
   logic             m_cyc;
   logic             hit_ram;
   logic             hit_io;
   logic             hit_tmr;
   logic             def_cyc;
   logic             def_ack_q;
   logic             s_ack;
   logic [WB_DW-1:0] s_dat_r;

   assign idle  = (gnt_q == 2'b00);
   assign sel_d = gnt_q[1] | (idle & i_dbus.cyc); // dbus wins a tie
   assign sel_i = gnt_q[0] | (idle & ~i_dbus.cyc & i_ibus.cyc);

   assign m_adr   = sel_d ? i_dbus.adr : i_ibus.adr;
   assign m_dat_w = sel_d ? i_dbus.dat_w : i_ibus.dat_w;
   assign m_sel   = sel_d ? i_dbus.sel : i_ibus.sel;
   assign m_we    = sel_d ? i_dbus.we : i_ibus.we;
   assign m_cyc   = (sel_d & i_dbus.cyc) | (sel_i & i_ibus.cyc);

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         gnt_q <= 2'b00;
      end else if (s_ack) begin
         gnt_q <= 2'b00;             // release on the granted ack
      end else if (idle && m_cyc) begin
         gnt_q <= {sel_d, sel_i};
      end
   end

   assign hit_ram = (m_adr.fields.region == REG_RAM);
   assign hit_io  = (m_adr.fields.region == REG_IO);
   assign hit_tmr = (m_adr.fields.region == REG_TIMER);
   assign def_cyc = m_cyc & ~(hit_ram | hit_io | hit_tmr);

   // same request on every slave, only cyc differs
   assign o_ram.adr   = m_adr;
   assign o_ram.dat_w = m_dat_w;
   assign o_ram.sel   = m_sel;
   assign o_ram.we    = m_we;
   assign o_ram.cyc   = m_cyc & hit_ram;
   assign o_io.adr    = m_adr;
   assign o_io.dat_w  = m_dat_w;
   assign o_io.sel    = m_sel;
   assign o_io.we     = m_we;
   assign o_io.cyc    = m_cyc & hit_io;
   assign o_tmr.adr   = m_adr;
   assign o_tmr.dat_w = m_dat_w;
   assign o_tmr.sel   = m_sel;
   assign o_tmr.we    = m_we;
   assign o_tmr.cyc   = m_cyc & hit_tmr;

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         def_ack_q <= 1'b0;
      end else begin
         def_ack_q <= def_cyc & ~def_ack_q; // unmapped space
      end
   end

   assign s_ack = o_ram.ack | o_io.ack | o_tmr.ack | def_ack_q;

   always_comb begin
      case (m_adr.fields.region)
         REG_RAM:   s_dat_r = o_ram.dat_r;
         REG_IO:    s_dat_r = o_io.dat_r;
         REG_TIMER: s_dat_r = o_tmr.dat_r;
         default:   s_dat_r = '0;
      endcase
   end

   assign i_dbus.dat_r = s_dat_r;
   assign i_dbus.ack   = sel_d & s_ack;
   assign i_ibus.dat_r = s_dat_r;
   assign i_ibus.ack   = sel_i & s_ack;

   a_gnt_onehot: assert property (@(posedge wb_clk) disable iff (wb_rst) $onehot0(gnt_q));
   a_ram_ack: assert property (@(posedge wb_clk) disable iff (wb_rst) o_ram.ack |-> o_ram.cyc);
   a_io_ack: assert property (@(posedge wb_clk) disable iff (wb_rst) o_io.ack |-> o_io.cyc);
   a_tmr_ack: assert property (@(posedge wb_clk) disable iff (wb_rst) o_tmr.ack |-> o_tmr.cyc);

endmodule

/* rtl/wb_bus_if.sv */
`timescale 1ns/10ps

interface wb_bus_if;
   import wb_bus_pkg::*;

   wb_addr_u         adr;
   logic [WB_DW-1:0] dat_w;
   logic [WB_SW-1:0] sel;
   logic             we;
   logic             cyc;   // also serves as stb
   logic [WB_DW-1:0] dat_r;
   logic             ack;

   modport master (
      output adr, dat_w, sel, we, cyc,
      input  dat_r, ack
   );

   modport slave (
      input  adr, dat_w, sel, we, cyc,
      output dat_r, ack
   );

endinterface

/* rtl/wb_map_pkg.sv */
package wb_map_pkg;

   // region codes, top nibble of the bus address
   localparam logic [3:0] REG_RAM   = 4'h0;
   localparam logic [3:0] REG_IO    = 4'h4;
   localparam logic [3:0] REG_TIMER = 4'h8;

   localparam int RAM_WORDS = 2048;
   localparam int RAM_AW    = 11; // log2 of RAM_WORDS

   // word offsets inside the i/o region
   localparam logic [11:0] IO_GPIO  = 12'd0;
   localparam logic [11:0] IO_PRINT = 12'd1;
   localparam logic [11:0] IO_HALT  = 12'd2;

   // word offsets inside the timer region
   localparam logic [11:0] TMR_MTIME    = 12'd0;
   localparam logic [11:0] TMR_MTIMECMP = 12'd1;

endpackage

/* rtl/wb_bus_pkg.sv */
package wb_bus_pkg;

   localparam int WB_AW = 32;
   localparam int WB_DW = 32;
   localparam int WB_SW = 4;

   // one address, seen whole or split into fields
   typedef union packed {
      logic [WB_AW-1:0] raw;
      struct packed {
         logic [3:0]  region;   // slave select
         logic [13:0] unused;
         logic [11:0] word;     // register or ram word
         logic [1:0]  byte_off;
      } fields;
   } wb_addr_u;

endpackage
